/* design/bus_pkg.sv */
/* Address map and shared types of the device bus.
   Regions are disjoint; anything outside them is unmapped and reads zero. */
package bus_pkg;

    // bus data width
    localparam int WORD_W = 32;

    // device picked by the address decode
    typedef enum logic [1:0] {
        DEV_NONE   = 2'd0,
        DEV_RAM    = 2'd1,
        DEV_TICKER = 2'd2,
        DEV_GPIO   = 2'd3
    } dev_sel_e;

    // ram region, compared against addr[31:24]
    localparam logic [7:0] RAM_REGION = 8'h00;

    // io regions, compared against addr[31:8]
    localparam logic [23:0] GPIO_REGION   = 24'h1fd004;
    localparam logic [23:0] TICKER_REGION = 24'h1fd005;

    // gpio register offsets, addr[7:0]
    localparam logic [7:0] GPIO_OUT_OFS = 8'h00;
    localparam logic [7:0] GPIO_IN_OFS  = 8'h04;

endpackage

/* design/data_bus.sv */
/* Combinational device decoder. The master holds its access while data_bus_stall
   is high; unmapped addresses read zero, never stall and enable no device. */
`timescale 1ns/1ns

module data_bus (
    input  logic                      clk,
    input  logic                      rst_n,

    // master side
    input  logic [31:0]               dev_access_addr,
    input  logic [3:0]                dev_access_byte_enable,
    input  logic                      dev_access_read,
    input  logic                      dev_access_write,
    input  logic [bus_pkg::WORD_W-1:0] dev_access_write_data,
    output logic [bus_pkg::WORD_W-1:0] dev_access_read_data,
    output logic                      data_bus_stall,

    // sram
    output logic [23:0]               ram_addr,
    output logic [3:0]                ram_byte_enable,
    output logic                      ram_read_enable,
    output logic                      ram_write_enable,
    input  logic [bus_pkg::WORD_W-1:0] read_data_from_ram,
    input  logic                      ram_stall,

    // ticker
    output logic                      ticker_read_enable,
    output logic                      ticker_write_enable,
    input  logic [bus_pkg::WORD_W-1:0] read_data_from_ticker,

    // gpio
    output logic [7:0]                gpio_addr,
    output logic                      gpio_read_enable,
    output logic                      gpio_write_enable,
    input  logic [bus_pkg::WORD_W-1:0] read_data_from_gpio,

    // write data shared by every device
    output logic [bus_pkg::WORD_W-1:0] write_data
);

    import bus_pkg::*;

    dev_sel_e dev_sel;

    // one decode, each region tested once
    always_comb begin
        if (dev_access_addr[31:24] == RAM_REGION) begin
            dev_sel = DEV_RAM;
        end else if (dev_access_addr[31:8] == GPIO_REGION) begin
            dev_sel = DEV_GPIO;
        end else if (dev_access_addr[31:8] == TICKER_REGION) begin
            dev_sel = DEV_TICKER;
        end else begin
            dev_sel = DEV_NONE;
        end
    end

    assign ram_addr        = dev_access_addr[23:0];
    assign ram_byte_enable = dev_access_byte_enable;
    assign gpio_addr       = dev_access_addr[7:0];
    assign write_data      = dev_access_write_data;

    // enables copy the master levels for the selected device only
    assign ram_read_enable     = (dev_sel == DEV_RAM) && dev_access_read;
    assign ram_write_enable    = (dev_sel == DEV_RAM) && dev_access_write;
    assign ticker_read_enable  = (dev_sel == DEV_TICKER) && dev_access_read;
    assign ticker_write_enable = (dev_sel == DEV_TICKER) && dev_access_write;
    assign gpio_read_enable    = (dev_sel == DEV_GPIO) && dev_access_read;
    assign gpio_write_enable   = (dev_sel == DEV_GPIO) && dev_access_write;

    // read return and stall
    always_comb begin
        dev_access_read_data = '0;
        data_bus_stall       = 1'b0;
        case (dev_sel)
            DEV_RAM: begin
                dev_access_read_data = read_data_from_ram;
                data_bus_stall       = ram_stall;
            end
            DEV_TICKER: begin
                dev_access_read_data = read_data_from_ticker;
            end
            DEV_GPIO: begin
                dev_access_read_data = read_data_from_gpio;
            end
            default: begin
                dev_access_read_data = '0;
                data_bus_stall       = 1'b0;
            end
        endcase
    end

endmodule

/* design/gpio_port.sv */
/* GPIO output register and two-flop synchronized inputs, GPIO_W <= 32.
   Offsets other than out and in read zero and ignore writes. */
`timescale 1ns/1ns

module gpio_port #(
    parameter int GPIO_W = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [7:0]                addr,
    input  logic                      read_enable,
    input  logic                      write_enable,
    input  logic [bus_pkg::WORD_W-1:0] write_data,
    output logic [bus_pkg::WORD_W-1:0] read_data,
    input  logic [GPIO_W-1:0]         gpio_in,
    output logic [GPIO_W-1:0]         gpio_out
);

    import bus_pkg::*;

    logic [GPIO_W-1:0] out_reg;
    logic [GPIO_W-1:0] in_meta;
    logic [GPIO_W-1:0] in_sync;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_reg <= '0;
        end else if (write_enable && addr == GPIO_OUT_OFS) begin
            out_reg <= write_data[GPIO_W-1:0];
        end
    end

    // pins are asynchronous
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    always_comb begin
        read_data = '0;
        if (read_enable) begin
            if (addr == GPIO_OUT_OFS) begin
                read_data[GPIO_W-1:0] = out_reg;
            end else if (addr == GPIO_IN_OFS) begin
                read_data[GPIO_W-1:0] = in_sync;
            end
        end
    end

    assign gpio_out = out_reg;

endmodule

/* design/soc_bus_top.sv */
/* Device bus with SRAM, ticker and GPIO behind one decoder.
   Access latency is that of the selected device. */
`timescale 1ns/1ns

module soc_bus_top #(
    parameter int RAM_ADDR_W = 8,
    parameter int RAM_WAIT   = 2,
    parameter int GPIO_W     = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [31:0]               dev_access_addr,
    input  logic [3:0]                dev_access_byte_enable,
    input  logic                      dev_access_read,
    input  logic                      dev_access_write,
    input  logic [bus_pkg::WORD_W-1:0] dev_access_write_data,
    output logic [bus_pkg::WORD_W-1:0] dev_access_read_data,
    output logic                      data_bus_stall,
    input  logic [GPIO_W-1:0]         gpio_in,
    output logic [GPIO_W-1:0]         gpio_out
);

    import bus_pkg::*;

    logic [23:0]       ram_addr;
    logic [3:0]        ram_byte_enable;
    logic              ram_read_enable;
    logic              ram_write_enable;
    logic [WORD_W-1:0] read_data_from_ram;
    logic              ram_stall;
    logic              ticker_read_enable;
    logic              ticker_write_enable;
    logic [WORD_W-1:0] read_data_from_ticker;
    logic [7:0]        gpio_addr;
    logic              gpio_read_enable;
    logic              gpio_write_enable;
    logic [WORD_W-1:0] read_data_from_gpio;
    logic [WORD_W-1:0] write_data;

    data_bus u_data_bus (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .dev_access_addr       (dev_access_addr),
        .dev_access_byte_enable(dev_access_byte_enable),
        .dev_access_read       (dev_access_read),
        .dev_access_write      (dev_access_write),
        .dev_access_write_data (dev_access_write_data),
        .dev_access_read_data  (dev_access_read_data),
        .data_bus_stall        (data_bus_stall),
        .ram_addr              (ram_addr),
        .ram_byte_enable       (ram_byte_enable),
        .ram_read_enable       (ram_read_enable),
        .ram_write_enable      (ram_write_enable),
        .read_data_from_ram    (read_data_from_ram),
        .ram_stall             (ram_stall),
        .ticker_read_enable    (ticker_read_enable),
        .ticker_write_enable   (ticker_write_enable),
        .read_data_from_ticker (read_data_from_ticker),
        .gpio_addr             (gpio_addr),
        .gpio_read_enable      (gpio_read_enable),
        .gpio_write_enable     (gpio_write_enable),
        .read_data_from_gpio   (read_data_from_gpio),
        .write_data            (write_data)
    );

    sram_ctrl #(
        .RAM_ADDR_W(RAM_ADDR_W),
        .RAM_WAIT  (RAM_WAIT)
    ) u_sram_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (ram_addr),
        .byte_enable (ram_byte_enable),
        .read_enable (ram_read_enable),
        .write_enable(ram_write_enable),
        .write_data  (write_data),
        .read_data   (read_data_from_ram),
        .stall       (ram_stall)
    );

    ticker u_ticker (
        .clk         (clk),
        .rst_n       (rst_n),
        .read_enable (ticker_read_enable),
        .write_enable(ticker_write_enable),
        .write_data  (write_data),
        .read_data   (read_data_from_ticker)
    );

    gpio_port #(
        .GPIO_W(GPIO_W)
    ) u_gpio_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (gpio_addr),
        .read_enable (gpio_read_enable),
        .write_enable(gpio_write_enable),
        .write_data  (write_data),
        .read_data   (read_data_from_gpio),
        .gpio_in     (gpio_in),
        .gpio_out    (gpio_out)
    );

endmodule

/* design/sram_ctrl.sv */
/* Word SRAM, RAM_WAIT stall cycles per access (RAM_WAIT >= 1), RAM_ADDR_W <= 22.
   Address bits above the array size alias; contents are not reset. */
`timescale 1ns/1ns

module sram_ctrl #(
    parameter int RAM_ADDR_W = 8,
    parameter int RAM_WAIT   = 2
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [23:0]               addr,
    input  logic [3:0]                byte_enable,
    input  logic                      read_enable,
    input  logic                      write_enable,
    input  logic [bus_pkg::WORD_W-1:0] write_data,
    output logic [bus_pkg::WORD_W-1:0] read_data,
    output logic                      stall
);

    import bus_pkg::*;

    localparam int CNT_W = $clog2(RAM_WAIT + 1);
    localparam int DEPTH = 2 ** RAM_ADDR_W;

    logic [WORD_W-1:0]     mem [DEPTH];
    logic [CNT_W-1:0]      wait_cnt;
    logic [RAM_ADDR_W-1:0] word_idx;
    logic                  active;
    logic                  done;

    // word index, byte offset dropped
    assign word_idx = addr[RAM_ADDR_W+1:2];

    assign active = read_enable || write_enable;
    assign done   = active && (wait_cnt == CNT_W'(RAM_WAIT));
    assign stall  = active && !done;

    // counts the stall cycles, cleared at completion so the next access waits again
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (!active || done) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // byte lane write at the completing edge
    always_ff @(posedge clk) begin
        if (write_enable && done) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byte_enable[lane]) begin
                    mem[word_idx][lane*8 +: 8] <= write_data[lane*8 +: 8];
                end
            end
        end
    end

    assign read_data = (read_enable && done) ? mem[word_idx] : '0;

endmodule

/* design/ticker.sv */
/* Free-running 32-bit cycle counter. A write loads the count at its edge;
   the count reads back at any offset inside the region. */
`timescale 1ns/1ns

module ticker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      read_enable,
    input  logic                      write_enable,
    input  logic [bus_pkg::WORD_W-1:0] write_data,
    output logic [bus_pkg::WORD_W-1:0] read_data
);

    import bus_pkg::*;

    logic [WORD_W-1:0] count;

    // load takes priority over the increment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (write_enable) begin
            count <= write_data;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign read_data = read_enable ? count : '0;

endmodule

/* run.sh */
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tb_soc_bus -o tb_soc_bus || exit 1
out=$(./obj_dir/tb_soc_bus)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Test passed" && echo "run ok" || { echo "run failed"; exit 1; }

/* testbench/soc_bus_assert.sv */
/* Decoder checks, bound into data_bus. Sampled on the rising clock edge
   and idle while reset is low. */
`timescale 1ns/1ns

module soc_bus_assert (
    input logic              clk,
    input logic              rst_n,
    input bus_pkg::dev_sel_e dev_sel,
    input logic              dev_access_read,
    input logic              dev_access_write,
    input logic              data_bus_stall,
    input logic              ram_read_enable,
    input logic              ram_write_enable,
    input logic              ticker_read_enable,
    input logic              ticker_write_enable,
    input logic              gpio_read_enable,
    input logic              gpio_write_enable
);

    import bus_pkg::*;

    logic ram_en;
    logic ticker_en;
    logic gpio_en;

    assign ram_en    = ram_read_enable || ram_write_enable;
    assign ticker_en = ticker_read_enable || ticker_write_enable;
    assign gpio_en   = gpio_read_enable || gpio_write_enable;

    one_device: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ram_en, ticker_en, gpio_en}))
        else $error("more than one device enabled");

    // only the sram can hold the master
    stall_from_ram: assert property (@(posedge clk) disable iff (!rst_n)
        data_bus_stall |-> dev_sel == DEV_RAM)
        else $error("stall raised while the ram is not selected");

    idle_no_enable: assert property (@(posedge clk) disable iff (!rst_n)
        !(dev_access_read || dev_access_write) |-> !(ram_en || ticker_en || gpio_en))
        else $error("device enabled with no master access");

endmodule

bind data_bus soc_bus_assert u_soc_bus_assert (
    .clk                (clk),
    .rst_n              (rst_n),
    .dev_sel            (dev_sel),
    .dev_access_read    (dev_access_read),
    .dev_access_write   (dev_access_write),
    .data_bus_stall     (data_bus_stall),
    .ram_read_enable    (ram_read_enable),
    .ram_write_enable   (ram_write_enable),
    .ticker_read_enable (ticker_read_enable),
    .ticker_write_enable(ticker_write_enable),
    .gpio_read_enable   (gpio_read_enable),
    .gpio_write_enable  (gpio_write_enable)
);

/* testbench/tb_soc_bus.sv */
/* Directed testbench for the device bus, DUT at default parameters.
   Inputs change on the falling clock edge; outputs are sampled 1 ns later. */
`timescale 1ns/1ns

module tb_soc_bus;

    localparam int          RAM_WAIT      = 2;
    localparam int          GPIO_W        = 16;
    localparam logic [23:0] GPIO_REGION   = 24'h1fd004;
    localparam logic [23:0] TICKER_REGION = 24'h1fd005;
    localparam logic [7:0]  GPIO_OUT_OFS  = 8'h00;
    localparam logic [7:0]  GPIO_IN_OFS   = 8'h04;
    localparam logic [31:0] UNMAPPED_ADDR = 32'h4000_0000;
    localparam int          STALL_LIMIT   = 50;
    localparam int          TICK_GAP      = 5;

    logic              clk;
    logic              rst_n;
    logic [31:0]       dev_access_addr;
    logic [3:0]        dev_access_byte_enable;
    logic              dev_access_read;
    logic              dev_access_write;
    logic [31:0]       dev_access_write_data;
    logic [31:0]       dev_access_read_data;
    logic              data_bus_stall;
    logic [GPIO_W-1:0] gpio_in;
    logic [GPIO_W-1:0] gpio_out;

    int          errors;
    int          tests_ok;
    int          tests_failing;
    int          last_stalls;
    logic [31:0] ram_addrs [8];
    // expected ram contents, one word per entry of ram_addrs
    logic [31:0] ram_model [8];

    soc_bus_top u_soc_bus_top (.*);

    always #2 clk = ~clk;

    task automatic show_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("FAIL %s expected 0x%08h got 0x%08h", name, expected, actual);
        errors++;
    endtask

    task automatic report_test(input string name, input int start);
        if (errors == start) begin
            $display("%s: ok", name);
            tests_ok++;
        end else begin
            $display("%s: %0d errors", name, errors - start);
            tests_failing++;
        end
    endtask

    // counts the stall cycles of the access on the bus
    task automatic wait_ready();
        int cycles;
        cycles = 0;
        #1;
        while (data_bus_stall && cycles < STALL_LIMIT) begin
            cycles++;
            @(negedge clk);
            #1;
        end
        if (data_bus_stall) begin
            $display("stall never released for address 0x%08h", dev_access_addr);
            errors++;
        end
        last_stalls = cycles;
    endtask

    // levels drop after the completing edge
    task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
        dev_access_addr        = addr;
        dev_access_byte_enable = be;
        dev_access_write_data  = data;
        dev_access_read        = 1'b0;
        dev_access_write       = 1'b1;
        wait_ready();
        @(negedge clk);
        dev_access_write = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        dev_access_addr        = addr;
        dev_access_byte_enable = 4'hf;
        dev_access_read        = 1'b1;
        dev_access_write       = 1'b0;
        wait_ready();
        // valid in the completing cycle
        data = dev_access_read_data;
        @(negedge clk);
        dev_access_read = 1'b0;
    endtask

    task automatic ram_byte_lanes();
        int          start;
        logic [31:0] word;
        logic [3:0]  be;
        start = errors;
        for (int i = 0; i < 8; i++) begin
            ram_addrs[i] = 32'(i) * 32'h44;
            ram_model[i] = $urandom;
            bus_write(ram_addrs[i], 4'hf, ram_model[i]);
        end
        // partial overwrite, only enabled lanes change
        for (int i = 0; i < 8; i++) begin
            word = $urandom;
            be   = 4'($urandom_range(14, 1));
            bus_write(ram_addrs[i], be, word);
            for (int lane = 0; lane < 4; lane++) begin
                if (be[lane]) ram_model[i][lane*8 +: 8] = word[lane*8 +: 8];
            end
        end
        for (int i = 0; i < 8; i++) begin
            bus_read(ram_addrs[i], word);
            if (word !== ram_model[i]) show_mismatch("dev_access_read_data", ram_model[i], word);
        end
        report_test("ram byte lanes", start);
    endtask

    task automatic ram_wait_states();
        int          start;
        int          first_stalls;
        logic [31:0] got;
        start = errors;
        // two reads with no idle cycle between them
        bus_read(ram_addrs[3], got);
        first_stalls = last_stalls;
        bus_read(ram_addrs[5], got);
        if (first_stalls != RAM_WAIT) begin
            show_mismatch("data_bus_stall cycles", 32'(RAM_WAIT), 32'(first_stalls));
        end
        if (last_stalls != RAM_WAIT) begin
            show_mismatch("data_bus_stall cycles", 32'(RAM_WAIT), 32'(last_stalls));
        end
        if (got !== ram_model[5]) show_mismatch("dev_access_read_data", ram_model[5], got);
        report_test("ram wait states", start);
    endtask

    task automatic ticker_load();
        int          start;
        logic [31:0] value;
        logic [31:0] got;
        start = errors;
        value = $urandom;
        bus_write({TICKER_REGION, 8'h00}, 4'hf, value);
        // first cycle after the load
        bus_read({TICKER_REGION, 8'h08}, got);
        if (got !== value) show_mismatch("dev_access_read_data", value, got);
        repeat (TICK_GAP) @(negedge clk);
        // one step at the first read's edge, then one per idle cycle
        bus_read({TICKER_REGION, 8'h00}, got);
        if (got !== value + 32'(TICK_GAP + 1)) begin
            show_mismatch("dev_access_read_data", value + 32'(TICK_GAP + 1), got);
        end
        report_test("ticker", start);
    endtask

    task automatic gpio_loopback();
        int                start;
        logic [31:0]       value;
        logic [31:0]       got;
        logic [GPIO_W-1:0] pins;
        start = errors;
        value = $urandom;
        bus_write({GPIO_REGION, GPIO_OUT_OFS}, 4'hf, value);
        if (gpio_out !== value[GPIO_W-1:0]) begin
            show_mismatch("gpio_out", 32'(value[GPIO_W-1:0]), 32'(gpio_out));
        end
        bus_read({GPIO_REGION, GPIO_OUT_OFS}, got);
        if (got !== 32'(value[GPIO_W-1:0])) begin
            show_mismatch("dev_access_read_data", 32'(value[GPIO_W-1:0]), got);
        end
        value   = $urandom;
        pins    = value[GPIO_W-1:0];
        gpio_in = pins;
        // two synchronizer edges and one spare
        repeat (3) @(negedge clk);
        bus_read({GPIO_REGION, GPIO_IN_OFS}, got);
        if (got !== 32'(pins)) show_mismatch("dev_access_read_data", 32'(pins), got);
        report_test("gpio", start);
    endtask

    task automatic unmapped_access();
        int                start;
        logic [31:0]       got;
        logic [GPIO_W-1:0] out_before;
        start      = errors;
        out_before = gpio_out;
        got        = $urandom;
        bus_write(UNMAPPED_ADDR, 4'hf, got);
        if (last_stalls != 0) show_mismatch("data_bus_stall cycles", 32'h0, 32'(last_stalls));
        bus_read(UNMAPPED_ADDR, got);
        if (last_stalls != 0) show_mismatch("data_bus_stall cycles", 32'h0, 32'(last_stalls));
        if (got !== 32'h0) show_mismatch("dev_access_read_data", 32'h0, got);
        if (gpio_out !== out_before) show_mismatch("gpio_out", 32'(out_before), 32'(gpio_out));
        // ram word 0 is where this address would alias
        bus_read(ram_addrs[0], got);
        if (got !== ram_model[0]) show_mismatch("dev_access_read_data", ram_model[0], got);
        report_test("unmapped address", start);
    endtask

    initial begin
        void'($urandom(32'h45e5));
        clk                    = 1'b0;
        rst_n                  = 1'b0;
        dev_access_addr        = '0;
        dev_access_byte_enable = '0;
        dev_access_read        = 1'b0;
        dev_access_write       = 1'b0;
        dev_access_write_data  = '0;
        gpio_in                = '0;
        errors                 = 0;
        tests_ok               = 0;
        tests_failing          = 0;
        last_stalls            = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        ram_byte_lanes();
        ram_wait_states();
        ticker_load();
        gpio_loopback();
        unmapped_access();
        $display("summary: %0d tests ok, %0d tests failing", tests_ok, tests_failing);
        if (tests_failing == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
design/bus_pkg.sv
design/data_bus.sv
design/sram_ctrl.sv
design/ticker.sv
design/gpio_port.sv
design/soc_bus_top.sv
testbench/soc_bus_assert.sv
testbench/tb_soc_bus.sv
